//--- flist.f
+incdir+include
src/motorPkg.sv
src/speedControl.sv
src/stepGenerator.sv
src/pwmCarrier.sv
src/phaseDriver.sv
src/motorDriveTop.sv
sim/motorDrive_asserts.sv
sim/motorDriveTb.sv

//--- include/motorDrive_defines.svh
`ifndef MOTORDRIVE_DEFINES_SVH
`define MOTORDRIVE_DEFINES_SVH

// step period and sub-step counter width.
`define STEP_CNT_WIDTH 25

// pwm counter and duty width.
`define PWM_WIDTH      8
`define PWM_TOP        100   // counter runs 0 .. PWM_TOP-1.

// speed control, in clk cycles per sub-step.
`define DEFAULT_PERIOD 40
`define MIN_PERIOD     8
`define MAX_PERIOD     200
`define PERIOD_DELTA   4

// phase position codes.
`define STEP_LAST      11
`define STEP_IDLE      15    // held from reset until the first start.

`endif

//--- sim/motorDriveTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module motorDriveTb
    import motorPkg::*;
();

    localparam int ClkPeriod = 8;
    localparam int NumRows   = 7;
    localparam int NumCols   = 7;
    localparam int RandDuty  = -1;
    localparam int ResetCycles = 5;

    // start, splitMax, duty, faster, slower, both, cycles.
    int stimTable [NumRows][NumCols] = '{
        '{1, 0, 50,       0,  0, 0, 600},    // default period.
        '{1, 3, RandDuty, 0,  0, 0, 800},
        '{1, 0, 0,        10, 0, 0, 400},    // down to MIN_PERIOD.
        '{1, 1, 100,      0, 50, 0, 1500},   // up to MAX_PERIOD.
        '{1, 2, 255,      5,  5, 3, 800},    // strobes together.
        '{0, 0, RandDuty, 3,  0, 0, 200},    // stopped, must hold.
        '{1, 0, RandDuty, 0,  0, 0, 600}     // restart.
    };

    logic       clk;
    logic       rstN;
    logic       start;
    logic       freqInc;
    logic       freqDec;
    splitStep_t splitMax;
    pwmCount_t  dutyCycle;
    stepIndex_t stepA;
    stepIndex_t stepB;
    stepIndex_t stepC;
    splitStep_t splitStep;
    logic       stepDone;
    logic [2:0] highGate;
    logic [2:0] lowGate;

    // reference model state.
    int         mPeriod;
    int         mCnt;
    int         mSplit;
    int         mStepA;
    int         mPwmCnt;
    bit         mStartD;
    logic [2:0] mHigh;
    logic [2:0] mLow;

    motorDriveTop uut (
        .clk(clk), .rstN(rstN), .start(start), .freqInc(freqInc), .freqDec(freqDec),
        .splitMax(splitMax), .dutyCycle(dutyCycle), .stepA(stepA), .stepB(stepB),
        .stepC(stepC), .splitStep(splitStep), .stepDone(stepDone),
        .highGate(highGate), .lowGate(lowGate)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int phasePos(input int a, input int off);
        return (a > `STEP_LAST) ? 14 : (a + off) % 12;
    endfunction

    function automatic gateState_e stateOf(input int pos);
        case (pos)
            0, 1, 2, 3: return GATE_HIGH;
            6, 7, 8, 9: return GATE_LOW;
            default:    return GATE_OFF;
        endcase
    endfunction

    function automatic bit doneNow();
        return start && mStartD && (mCnt <= 1) && (mSplit == 0);
    endfunction

    task automatic advanceModel();
        bit startUp;
        bit subEnd;
        bit pwmOn;
        int nextPeriod;
        gateState_e st;
        startUp = start && !mStartD;
        subEnd  = start && mStartD && (mCnt <= 1);
        pwmOn   = mPwmCnt < int'(dutyCycle);
        for (int i = 0; i < 3; i++) begin
            st       = stateOf(phasePos(mStepA, (12 - 4 * i) % 12));   // A +0, B +8, C +4.
            mHigh[i] = (st == GATE_HIGH) && pwmOn;
            mLow[i]  = (st == GATE_LOW);
        end
        nextPeriod = mPeriod;
        if (freqInc && !freqDec) begin
            nextPeriod = mPeriod - `PERIOD_DELTA;
            if (nextPeriod < `MIN_PERIOD)
                nextPeriod = `MIN_PERIOD;
        end else if (freqDec && !freqInc) begin
            nextPeriod = mPeriod + `PERIOD_DELTA;
            if (nextPeriod > `MAX_PERIOD)
                nextPeriod = `MAX_PERIOD;
        end
        if (startUp) begin
            mStepA = 0;
        end else if (doneNow()) begin
            mStepA = (mStepA + 1) % 12;
        end
        if (startUp || subEnd) begin
            mSplit = (startUp || mSplit == 0) ? int'(splitMax) : mSplit - 1;
            mCnt   = mPeriod;   // reload with the period in force now.
        end else if (start) begin
            mCnt = mCnt - 1;
        end
        mPwmCnt = (mPwmCnt + 1) % `PWM_TOP;
        mStartD = start;
        mPeriod = nextPeriod;
    endtask

    always @(negedge clk) begin
        if (!rstN) begin
            mPeriod = `DEFAULT_PERIOD;
            mCnt    = `DEFAULT_PERIOD;
            mSplit  = int'(splitMax);
            mStepA  = `STEP_IDLE;
            mPwmCnt = 0;
            mStartD = 1'b0;
            mHigh   = '0;
            mLow    = '0;
        end else begin
            checkEqual(stepA, mStepA, "stepA");
            checkEqual(stepB, phasePos(mStepA, 8), "stepB");
            checkEqual(stepC, phasePos(mStepA, 4), "stepC");
            checkEqual(splitStep, mSplit, "splitStep");
            checkEqual(stepDone, doneNow(), "stepDone");
            checkEqual(highGate, mHigh, "highGate");
            checkEqual(lowGate, mLow, "lowGate");
            advanceModel();
        end
    end

    // gate and step sequence assertions.
    always @(negedge clk) begin
        if (uut.uPhase.uGateChk.failCount != 0) begin
            $display("a bound gate or step assertion failed before %0t ns", $time);
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    // watchdog, twice the table length plus reset.
    initial begin
        int total;
        total = ResetCycles;
        for (int r = 0; r < NumRows; r++) begin
            total += stimTable[r][6];
        end
        #(total * 2 * ClkPeriod);
        $display("timeout: stimulus did not finish within %0d ns", total * 2 * ClkPeriod);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int remFast;
        int remSlow;
        int remBoth;
        int pend;
        bit incNow;
        bit decNow;
        void'($urandom(89));
        rstN = 1'b0;
        clk = 1'b0;
        start = 1'b0;
        freqInc = 1'b0;
        freqDec = 1'b0;
        splitMax = '0;
        dutyCycle = '0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkEqual(stepA, `STEP_IDLE, "stepA after reset");
        checkEqual(stepB, 14, "stepB after reset");
        checkEqual(stepC, 14, "stepC after reset");
        checkEqual({highGate, lowGate}, 0, "gates after reset");
        checkEqual(stepDone, 0, "stepDone after reset");
        for (int r = 0; r < NumRows; r++) begin
            remFast = stimTable[r][3];
            remSlow = stimTable[r][4];
            remBoth = stimTable[r][5];
            for (int c = 0; c < stimTable[r][6]; c++) begin
                @(posedge clk);
                if (c == 0) begin
                    start    <= (stimTable[r][0] != 0);
                    splitMax <= splitStep_t'(stimTable[r][1]);
                    dutyCycle <= (stimTable[r][2] == RandDuty) ?
                        pwmCount_t'($urandom_range(1, `PWM_TOP - 1)) : pwmCount_t'(stimTable[r][2]);
                end
                pend   = remFast + remSlow + remBoth;
                incNow = 1'b0;
                decNow = 1'b0;
                // strobes land at random, forced once the row runs short.
                if (pend > 0 && (pend >= stimTable[r][6] - c || $urandom_range(0, 7) == 0)) begin
                    if (remBoth > 0) begin
                        incNow = 1'b1;
                        decNow = 1'b1;
                        remBoth--;
                    end else if (remFast > 0) begin
                        incNow = 1'b1;
                        remFast--;
                    end else begin
                        decNow = 1'b1;
                        remSlow--;
                    end
                end
                freqInc <= incNow;
                freqDec <= decNow;
            end
        end
        @(posedge clk);
        freqInc <= 1'b0;
        freqDec <= 1'b0;
        @(negedge clk);
        @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/motorDrive_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module motorDriveAsserts
    import motorPkg::*;
(
    input logic       clk,
    input logic       rstN,
    input stepIndex_t stepA,
    input stepIndex_t stepB,
    input stepIndex_t stepC,
    input logic [2:0] highGate,
    input logic [2:0] lowGate
);

    int failCount = 0;   // failed assertions so far.

    // position moved forward by off, modulo 12.
    function automatic stepIndex_t offsetPos(input stepIndex_t pos, input int off);
        return stepIndex_t'((int'(pos) + off) % 12);
    endfunction

    gateExclusive: assert property (@(posedge clk) disable iff (!rstN)
        (highGate & lowGate) == 3'b000)
        else begin
            $error("shoot-through, highGate %b lowGate %b", highGate, lowGate);
            failCount++;
        end

    stepRange: assert property (@(posedge clk) disable iff (!rstN)
        (stepA <= `STEP_LAST) || (stepA == `STEP_IDLE))
        else begin
            $error("stepA out of range: %0d", stepA);
            failCount++;
        end

    phaseOffsets: assert property (@(posedge clk) disable iff (!rstN)
        (stepA <= `STEP_LAST) |-> (stepB == offsetPos(stepA, 8)) && (stepC == offsetPos(stepA, 4)))
        else begin
            $error("phase offsets wrong, A %0d B %0d C %0d", stepA, stepB, stepC);
            failCount++;
        end

    idleCodes: assert property (@(posedge clk) disable iff (!rstN)
        (stepA == `STEP_IDLE) |-> (stepB == 4'hE) && (stepC == 4'hE))
        else begin
            $error("idle B/C code wrong, B %0d C %0d", stepB, stepC);
            failCount++;
        end

endmodule

bind phaseDriver motorDriveAsserts uGateChk (
    .clk(clk), .rstN(rstN), .stepA(stepA), .stepB(stepB), .stepC(stepC),
    .highGate(highGate), .lowGate(lowGate)
);

`default_nettype wire

//--- src/motorDriveTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module motorDriveTop
    import motorPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  logic       freqInc,
    input  logic       freqDec,
    input  splitStep_t splitMax,
    input  pwmCount_t  dutyCycle,
    output stepIndex_t stepA,
    output stepIndex_t stepB,
    output stepIndex_t stepC,
    output splitStep_t splitStep,
    output logic       stepDone,
    output logic [2:0] highGate,
    output logic [2:0] lowGate
);

    stepCount_t stepPeriod;
    logic       pwmOn;

    speedControl uSpeed (
        .clk        (clk),
        .rstN       (rstN),
        .freqInc    (freqInc),
        .freqDec    (freqDec),
        .stepPeriod (stepPeriod)
    );

    stepGenerator uStep (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .splitMax   (splitMax),
        .stepPeriod (stepPeriod),
        .stepA      (stepA),
        .stepB      (stepB),
        .stepC      (stepC),
        .splitStep  (splitStep),
        .stepDone   (stepDone)
    );

    pwmCarrier uPwm (
        .clk       (clk),
        .rstN      (rstN),
        .dutyCycle (dutyCycle),
        .pwmOn     (pwmOn)
    );

    phaseDriver uPhase (
        .clk      (clk),
        .rstN     (rstN),
        .stepA    (stepA),
        .stepB    (stepB),
        .stepC    (stepC),
        .pwmOn    (pwmOn),
        .highGate (highGate),
        .lowGate  (lowGate)
    );

endmodule

`default_nettype wire

//--- src/motorPkg.sv
`default_nettype none

`include "motorDrive_defines.svh"

package motorPkg;

    // electrical position, 0..11 valid.
    typedef logic [3:0] stepIndex_t;

    typedef logic [1:0] splitStep_t;   // extra sub-steps per position.

    typedef logic [`STEP_CNT_WIDTH-1:0] stepCount_t;

    typedef logic [`PWM_WIDTH-1:0] pwmCount_t;

    // drive state of one half-bridge.
    typedef enum logic [1:0] {
        GATE_OFF  = 2'd0,
        GATE_HIGH = 2'd1,
        GATE_LOW  = 2'd2
    } gateState_e;

endpackage

`default_nettype wire

//--- src/phaseDriver.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module phaseDriver
    import motorPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  stepIndex_t stepA,
    input  stepIndex_t stepB,
    input  stepIndex_t stepC,
    input  logic       pwmOn,
    output logic [2:0] highGate,   // bit 0 is phase A.
    output logic [2:0] lowGate
);

    stepIndex_t phaseStep [3];
    gateState_e phaseState [3];
    logic [2:0] highNext;
    logic [2:0] lowNext;

    // position to half-bridge state.
    function automatic gateState_e gateOf(input stepIndex_t pos);
        gateState_e state;
        if (pos > stepIndex_t'(`STEP_LAST)) begin
            state = GATE_OFF;   // idle and invalid codes float the bridge.
        end
        else if (pos <= 4'd3) begin
            state = GATE_HIGH;
        end
        else if (pos >= 4'd6 && pos <= 4'd9) begin
            state = GATE_LOW;
        end
        else begin
            state = GATE_OFF;
        end
        return state;
    endfunction

    assign phaseStep[0] = stepA;
    assign phaseStep[1] = stepB;
    assign phaseStep[2] = stepC;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            phaseState[i] = gateOf(phaseStep[i]);
            highNext[i]   = (phaseState[i] == GATE_HIGH) & pwmOn;   // chopped high side.
            lowNext[i]    = (phaseState[i] == GATE_LOW);
        end
    end

    // high and low come from exclusive states, so never both on.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            highGate <= '0;
            lowGate  <= '0;
        end
        else begin
            highGate <= highNext;
            lowGate  <= lowNext;
        end
    end

endmodule

`default_nettype wire

//--- src/pwmCarrier.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module pwmCarrier
    import motorPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  pwmCount_t dutyCycle,
    output logic      pwmOn
);

    pwmCount_t pwmCnt;
    logic      pwmWrap;

    assign pwmWrap = (pwmCnt == pwmCount_t'(`PWM_TOP - 1));

    // free running carrier, no enable.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pwmCnt <= '0;
        end
        else if (pwmWrap) begin
            pwmCnt <= '0;
        end
        else begin
            pwmCnt <= pwmCnt + 1'b1;
        end
    end

    // duty 0 never fires, duty >= PWM_TOP always does.
    assign pwmOn = (pwmCnt < dutyCycle);

endmodule

`default_nettype wire

//--- src/speedControl.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module speedControl
    import motorPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       freqInc,     // faster, one cycle strobe.
    input  logic       freqDec,     // slower, one cycle strobe.
    output stepCount_t stepPeriod
);

    stepCount_t periodNext;
    logic       goFaster;
    logic       goSlower;

    // both strobes together cancel out.
    assign goFaster = freqInc & ~freqDec;
    assign goSlower = freqDec & ~freqInc;

    always_comb begin
        periodNext = stepPeriod;
        if (goFaster) begin
            // shorter period means a faster step rate.
            if (stepPeriod < stepCount_t'(`MIN_PERIOD + `PERIOD_DELTA)) begin
                periodNext = stepCount_t'(`MIN_PERIOD);
            end
            else begin
                periodNext = stepPeriod - stepCount_t'(`PERIOD_DELTA);
            end
        end
        else if (goSlower) begin
            if (stepPeriod > stepCount_t'(`MAX_PERIOD - `PERIOD_DELTA)) begin
                periodNext = stepCount_t'(`MAX_PERIOD);
            end
            else begin
                periodNext = stepPeriod + stepCount_t'(`PERIOD_DELTA);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stepPeriod <= stepCount_t'(`DEFAULT_PERIOD);
        end
        else begin
            stepPeriod <= periodNext;   // new period seen one cycle after the strobe.
        end
    end

endmodule

`default_nettype wire

//--- src/stepGenerator.sv
`timescale 1ns/100ps
`default_nettype none

`include "motorDrive_defines.svh"

module stepGenerator
    import motorPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  splitStep_t splitMax,
    input  stepCount_t stepPeriod,
    output stepIndex_t stepA,
    output stepIndex_t stepB,
    output stepIndex_t stepC,
    output splitStep_t splitStep,
    output logic       stepDone
);

    logic       startD;
    logic       startUp;
    stepCount_t subCnt;
    logic       cntLast;
    logic       subEnd;

    assign startUp = start & ~startD;
    assign cntLast = (subCnt[`STEP_CNT_WIDTH-1:1] == '0);   // count at 1 (or 0).
    assign subEnd  = start & cntLast & ~startUp;

    // last cycle of the final sub-step of a position.
    assign stepDone = subEnd & (splitStep == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            startD <= 1'b0;
        end
        else begin
            startD <= start;
        end
    end

    // sub-step counter, holds while start is low.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            subCnt <= stepCount_t'(`DEFAULT_PERIOD);
        end
        else if (startUp || subEnd) begin
            subCnt <= stepPeriod;   // period changes land here.
        end
        else if (start) begin
            subCnt <= subCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            splitStep <= splitMax;
        end
        else if (startUp) begin
            splitStep <= splitMax;
        end
        else if (subEnd) begin
            if (splitStep == '0) begin
                splitStep <= splitMax;
            end
            else begin
                splitStep <= splitStep - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stepA <= stepIndex_t'(`STEP_IDLE);
        end
        else if (startUp) begin
            stepA <= '0;
        end
        else if (stepDone) begin
            if (stepA == stepIndex_t'(`STEP_LAST)) begin
                stepA <= '0;
            end
            else begin
                stepA <= stepA + 1'b1;
            end
        end
    end

    // phase B trails by 4 positions, C leads by 4, i.e. +8 and +4 mod 12.
    always_comb begin
        if (stepA > stepIndex_t'(`STEP_LAST)) begin
            stepB = 4'hE;   // invalid marker.
            stepC = 4'hE;
        end
        else begin
            stepB = (stepA >= 4'd4) ? stepA - 4'd4 : stepA + 4'd8;
            stepC = (stepA >= 4'd8) ? stepA - 4'd8 : stepA + 4'd4;
        end
    end

endmodule

`default_nettype wire
